// File: list.f
source/isaPkg.sv
source/decodePkg.sv
source/unitClassifier.sv
source/memClassifier.sv
source/operandDecoder.sv
source/decodeStage.sv
source/instrDecoder.sv
verif/instrDecoderTb.sv

// File: source/decodePkg.sv
// Decoder output types and default widths for constants and queue tags
package decodePkg;

	// Default queue-tag width
	localparam int DefIdWidth = 5;

	// Default width of the extended constant
	localparam int DefConstWidth = 64;

	// Full sign-extended constant
	typedef logic [63:0] constT;

	// Instruction length in bytes (2, 4 or 6)
	typedef logic [2:0] lenT;

endpackage

// File: source/decodeStage.sv
// Decode output register: captures the flags, gates on destination, applies prediction
`timescale 1ns/1ps

module decodeStage #(
	parameter int IdWidth = decodePkg::DefIdWidth,
	parameter int ConstWidth = decodePkg::DefConstWidth
) (
	input  logic                  clk,
	input  logic                  arstN_i,
	input  logic                  idv_i,
	input  logic [IdWidth-1:0]    id_i,
	input  isaPkg::regIdxT        rt_i,
	input  logic                  predictTaken_i,
	input  logic                  isAlu_i,
	input  logic                  isAlu0_i,
	input  logic                  isFpu_i,
	input  logic                  isFlowCtrl_i,
	input  logic                  isBranch_i,
	input  logic                  isJump_i,
	input  logic                  isSync_i,
	input  logic                  isLoad_i,
	input  logic                  isMem_i,
	input  logic                  isMemNdx_i,
	input  logic                  isRmw_i,
	input  logic                  canExcept_i,
	input  logic                  src1Valid_i,
	input  logic                  src2Valid_i,
	input  logic                  src3Valid_i,
	input  logic                  hasConst_i,
	input  logic                  isRfw_i,
	input  logic [ConstWidth-1:0] const_i,
	input  decodePkg::lenT        len_i,
	output logic                  idv_o,
	output logic [IdWidth-1:0]    id_o,
	output logic [ConstWidth-1:0] const_o,
	output decodePkg::lenT        len_o,
	output logic                  isAlu_o,
	output logic                  isAlu0_o,
	output logic                  isFpu_o,
	output logic                  isFlowCtrl_o,
	output logic                  isBranch_o,
	output logic                  branchTaken_o,
	output logic                  isJump_o,
	output logic                  isSync_o,
	output logic                  isLoad_o,
	output logic                  preload_o,
	output logic                  isMem_o,
	output logic                  isMemNdx_o,
	output logic                  isRmw_o,
	output logic                  canExcept_o,
	output logic                  src1Valid_o,
	output logic                  src2Valid_o,
	output logic                  src3Valid_o,
	output logic                  hasConst_o,
	output logic                  rfw_o
);
	import isaPkg::*;

	logic rtZero;

	// Writes to register 0 are discarded
	assign rtZero = rt_i == regIdxT'(0);

	always_ff @(posedge clk or negedge arstN_i)
	begin
		if (!arstN_i)
			idv_o <= 1'b0;
		else
			idv_o <= idv_i;
	end

	// ==============================
	// Payload register
	// ==============================
	always_ff @(posedge clk)
	begin
		id_o <= id_i;
		const_o <= const_i;
		len_o <= len_i;
		isAlu_o <= isAlu_i;
		isAlu0_o <= isAlu0_i;
		isFpu_o <= isFpu_i;
		isFlowCtrl_o <= isFlowCtrl_i;
		isBranch_o <= isBranch_i;
		branchTaken_o <= isBranch_i & predictTaken_i;
		isJump_o <= isJump_i;
		isSync_o <= isSync_i;
		isLoad_o <= isLoad_i;
		// Load into r0 only warms the cache
		preload_o <= isLoad_i & rtZero;
		isMem_o <= isMem_i;
		isMemNdx_o <= isMemNdx_i;
		isRmw_o <= isRmw_i;
		canExcept_o <= canExcept_i;
		src1Valid_o <= src1Valid_i;
		src2Valid_o <= src2Valid_i;
		src3Valid_o <= src3Valid_i;
		hasConst_o <= hasConst_i;
		rfw_o <= isRfw_i & ~rtZero;
	end

	// Memory and unit classifiers must agree on a decoded instruction
	loadIsMem: assert property (@(posedge clk) disable iff (!arstN_i)
		idv_o && isLoad_o |-> isMem_o);

	branchIsFlow: assert property (@(posedge clk) disable iff (!arstN_i)
		idv_o && isBranch_o |-> isFlowCtrl_o);

	idvKnown: assert property (@(posedge clk) disable iff (!arstN_i)
		!$isunknown(idv_o));

endmodule

// File: source/instrDecoder.sv
// Instruction pre-decoder top: three classifiers feeding one output register stage
`timescale 1ns/1ps

module instrDecoder #(
	parameter int IdWidth = decodePkg::DefIdWidth,
	parameter int ConstWidth = decodePkg::DefConstWidth
) (
	input  logic                  clk,
	input  logic                  arstN_i,
	input  logic                  idv_i,
	input  logic [IdWidth-1:0]    id_i,
	input  isaPkg::instrT         instr_i,
	input  isaPkg::regIdxT        rt_i,
	input  logic                  predictTaken_i,
	output logic                  idv_o,
	output logic [IdWidth-1:0]    id_o,
	output logic [ConstWidth-1:0] const_o,
	output decodePkg::lenT        len_o,
	output logic                  isAlu_o,
	output logic                  isAlu0_o,
	output logic                  isFpu_o,
	output logic                  isFlowCtrl_o,
	output logic                  isBranch_o,
	output logic                  branchTaken_o,
	output logic                  isJump_o,
	output logic                  isSync_o,
	output logic                  isLoad_o,
	output logic                  preload_o,
	output logic                  isMem_o,
	output logic                  isMemNdx_o,
	output logic                  isRmw_o,
	output logic                  canExcept_o,
	output logic                  src1Valid_o,
	output logic                  src2Valid_o,
	output logic                  src3Valid_o,
	output logic                  hasConst_o,
	output logic                  rfw_o
);
	import decodePkg::*;

	logic isAlu, isAlu0, isFpu, isFlowCtrl, isBranch, isJump, isSync;
	logic isLoad, isMem, isMemNdx, isRmw, canExcept;
	logic src1Valid, src2Valid, src3Valid, hasConst, isRfw;
	logic [ConstWidth-1:0] constVal;
	lenT instrLen;

	// ==============================
	// Combinational classifiers
	// ==============================
	unitClassifier i_unitClassifier (
		.instr_i      (instr_i),
		.isAlu_o      (isAlu),
		.isAlu0_o     (isAlu0),
		.isFpu_o      (isFpu),
		.isFlowCtrl_o (isFlowCtrl),
		.isBranch_o   (isBranch),
		.isJump_o     (isJump),
		.isSync_o     (isSync)
	);

	memClassifier i_memClassifier (
		.instr_i     (instr_i),
		.isLoad_o    (isLoad),
		.isMem_o     (isMem),
		.isMemNdx_o  (isMemNdx),
		.isRmw_o     (isRmw),
		.canExcept_o (canExcept)
	);

	operandDecoder #(
		.ConstWidth (ConstWidth)
	) i_operandDecoder (
		.instr_i     (instr_i),
		.src1Valid_o (src1Valid),
		.src2Valid_o (src2Valid),
		.src3Valid_o (src3Valid),
		.hasConst_o  (hasConst),
		.isRfw_o     (isRfw),
		.const_o     (constVal),
		.len_o       (instrLen)
	);

	// Single register stage gives the one-cycle latency
	decodeStage #(
		.IdWidth    (IdWidth),
		.ConstWidth (ConstWidth)
	) i_decodeStage (
		.clk            (clk),
		.arstN_i        (arstN_i),
		.idv_i          (idv_i),
		.id_i           (id_i),
		.rt_i           (rt_i),
		.predictTaken_i (predictTaken_i),
		.isAlu_i        (isAlu),
		.isAlu0_i       (isAlu0),
		.isFpu_i        (isFpu),
		.isFlowCtrl_i   (isFlowCtrl),
		.isBranch_i     (isBranch),
		.isJump_i       (isJump),
		.isSync_i       (isSync),
		.isLoad_i       (isLoad),
		.isMem_i        (isMem),
		.isMemNdx_i     (isMemNdx),
		.isRmw_i        (isRmw),
		.canExcept_i    (canExcept),
		.src1Valid_i    (src1Valid),
		.src2Valid_i    (src2Valid),
		.src3Valid_i    (src3Valid),
		.hasConst_i     (hasConst),
		.isRfw_i        (isRfw),
		.const_i        (constVal),
		.len_i          (instrLen),
		.idv_o          (idv_o),
		.id_o           (id_o),
		.const_o        (const_o),
		.len_o          (len_o),
		.isAlu_o        (isAlu_o),
		.isAlu0_o       (isAlu0_o),
		.isFpu_o        (isFpu_o),
		.isFlowCtrl_o   (isFlowCtrl_o),
		.isBranch_o     (isBranch_o),
		.branchTaken_o  (branchTaken_o),
		.isJump_o       (isJump_o),
		.isSync_o       (isSync_o),
		.isLoad_o       (isLoad_o),
		.preload_o      (preload_o),
		.isMem_o        (isMem_o),
		.isMemNdx_o     (isMemNdx_o),
		.isRmw_o        (isRmw_o),
		.canExcept_o    (canExcept_o),
		.src1Valid_o    (src1Valid_o),
		.src2Valid_o    (src2Valid_o),
		.src3Valid_o    (src3Valid_o),
		.hasConst_o     (hasConst_o),
		.rfw_o          (rfw_o)
	);

endmodule

// File: source/isaPkg.sv
// Instruction-set definitions: word layout, opcodes and function codes
package isaPkg;

	typedef logic [47:0] instrT;
	typedef logic [5:0] opcodeT;
	typedef logic [5:0] funcT;
	typedef logic [4:0] regIdxT;
	typedef logic [1:0] lenFieldT;

	// Field positions, lsb of each field
	localparam int fieldOp = 0;
	localparam int fieldLen = 6;
	localparam int fieldRa = 8;
	localparam int fieldRb = 13;
	localparam int fieldRc = 18;
	localparam int fieldR1Func = 18;
	localparam int fieldS2 = 26;

	// Length field encodings, any other value is the 2-byte form
	localparam lenFieldT lenFour = 2'b00;
	localparam lenFieldT lenSix = 2'b01;

	// ==============================
	// Primary opcodes
	// ==============================
	localparam opcodeT opBrk = 6'h00, opR2 = 6'h02, opAddi = 6'h04, opCsrrw = 6'h05;
	localparam opcodeT opSlti = 6'h06, opSltui = 6'h07, opAndi = 6'h08, opOri = 6'h09;
	localparam opcodeT opXori = 6'h0a, opXnori = 6'h0b, opMului = 6'h0c, opMuli = 6'h0d;
	localparam opcodeT opDivui = 6'h0e, opDivi = 6'h0f, opFloat = 6'h10, opBitfield = 6'h11;
	localparam opcodeT opSgti = 6'h12, opSgtui = 6'h13, opModi = 6'h14, opInc = 6'h15;
	localparam opcodeT opMemNdx = 6'h16, opAmo = 6'h17, opLb = 6'h18, opLbu = 6'h19;
	localparam opcodeT opLx = 6'h1a, opLxu = 6'h1b, opLwr = 6'h1c, opLv = 6'h1d;
	localparam opcodeT opCas = 6'h1e, opSb = 6'h20, opSx = 6'h21, opSwc = 6'h22;
	localparam opcodeT opSv = 6'h23, opBcc = 6'h28, opBbc = 6'h29, opBeqi = 6'h2a;
	localparam opcodeT opChk = 6'h2b, opJal = 6'h30, opJmp = 6'h31, opCall = 6'h32;
	localparam opcodeT opRet = 6'h33;

	// ==============================
	// Function codes in S2
	// ==============================
	// R2 group
	localparam funcT fnR1 = 6'h01, fnAdd = 6'h04, fnSub = 6'h05, fnSlt = 6'h06;
	localparam funcT fnSltu = 6'h07, fnAnd = 6'h08, fnOr = 6'h09, fnXor = 6'h0a;
	localparam funcT fnMov = 6'h0b, fnMaj = 6'h0c, fnShiftR = 6'h10, fnMin = 6'h11;
	localparam funcT fnMax = 6'h12, fnMulu = 6'h18, fnMulsu = 6'h19, fnMul = 6'h1a;
	localparam funcT fnDivModu = 6'h1c, fnDivModsu = 6'h1d, fnDivMod = 6'h1e;
	localparam funcT fnRti = 6'h32;

	// MEMNDX group, indexed loads then stores
	localparam funcT fnLbx = 6'h00, fnLbux = 6'h01, fnLcx = 6'h02, fnLcux = 6'h03;
	localparam funcT fnLhx = 6'h04, fnLhux = 6'h05, fnLwx = 6'h06, fnLwrx = 6'h07;
	localparam funcT fnLvx = 6'h08, fnSbx = 6'h10, fnScx = 6'h11, fnShx = 6'h12;
	localparam funcT fnSwx = 6'h13, fnSwcx = 6'h14, fnSvx = 6'h15, fnIncx = 6'h16;
	localparam funcT fnCasx = 6'h17;

	// FLOAT group
	localparam funcT fnFadd = 6'h04, fnFsub = 6'h05, fnFmul = 6'h08, fnFdiv = 6'h09;

	// R1 sub-function, sits in the Rc slot
	localparam regIdxT fnSync = 5'h02;

	// Field extraction helpers
	function automatic opcodeT opOf(instrT instr);
		return instr[fieldOp +: $bits(opcodeT)];
	endfunction

	function automatic funcT funcOf(instrT instr);
		return instr[fieldS2 +: $bits(funcT)];
	endfunction

	function automatic lenFieldT lenOf(instrT instr);
		return instr[fieldLen +: $bits(lenFieldT)];
	endfunction

	function automatic regIdxT regOf(instrT instr, int pos);
		return instr[pos +: $bits(regIdxT)];
	endfunction

endpackage

// File: source/memClassifier.sv
// Memory classifier: access class and exception potential of one instruction
`timescale 1ns/1ps

module memClassifier (
	input  isaPkg::instrT instr_i,
	output logic          isLoad_o,
	output logic          isMem_o,
	output logic          isMemNdx_o,
	output logic          isRmw_o,
	output logic          canExcept_o
);
	import isaPkg::*;

	opcodeT op;
	funcT fn;
	logic ndxShort;

	assign op = opOf(instr_i);
	assign fn = funcOf(instr_i);

	// Indexed forms decode S2 only with the 4-byte length
	assign ndxShort = op == opMemNdx && lenOf(instr_i) == lenFour;

	// ==============================
	// Access class
	// ==============================
	always_comb
	begin
		case (op)
			opMemNdx:
				isLoad_o = ndxShort && (fn inside {fnLbx, fnLbux, fnLcx, fnLcux,
					fnLhx, fnLhux, fnLwx, fnLwrx, fnLvx});
			opLb, opLbu, opLx, opLxu, opLwr, opLv:
				isLoad_o = 1'b1;
			default:
				isLoad_o = 1'b0;
		endcase
	end

	always_comb
	begin
		case (op)
			opMemNdx, opAmo, opInc, opCas:
				isMem_o = 1'b1;
			opLb, opLbu, opLx, opLxu, opLwr, opLv:
				isMem_o = 1'b1;
			opSb, opSx, opSwc, opSv:
				isMem_o = 1'b1;
			default:
				isMem_o = 1'b0;
		endcase
	end

	assign isMemNdx_o = op == opMemNdx;

	// Atomics, increment and compare-and-swap hold the line across read and write
	assign isRmw_o = (op inside {opCas, opAmo, opInc})
		|| (ndxShort && (fn inside {fnCasx, fnIncx}));

	// ==============================
	// Exceptions
	// ==============================
	always_comb
	begin
		case (op)
			opFloat:
				canExcept_o = fn inside {fnFadd, fnFsub, fnFmul, fnFdiv};
			opAddi, opDivi, opModi, opMuli:
				canExcept_o = 1'b1;
			opR2:
				canExcept_o = fn inside {fnAdd, fnSub, fnMul, fnDivMod, fnMulsu,
					fnDivModsu, fnRti};
			opBcc, opBeqi, opChk:
				canExcept_o = 1'b1;
			// No write buffer, so stores may fault too
			default:
				canExcept_o = isMem_o;
		endcase
	end

endmodule

// File: source/operandDecoder.sv
// Operand decoder: source validity, register write, constant and length
`timescale 1ns/1ps

module operandDecoder #(
	parameter int ConstWidth = decodePkg::DefConstWidth
) (
	input  isaPkg::instrT           instr_i,
	output logic                    src1Valid_o,
	output logic                    src2Valid_o,
	output logic                    src3Valid_o,
	output logic                    hasConst_o,
	output logic                    isRfw_o,
	output logic [ConstWidth-1:0]   const_o,
	output decodePkg::lenT          len_o
);
	import isaPkg::*;
	import decodePkg::*;

	// Constant field spans
	localparam int ConstLo = 18;
	localparam int ShortConstBits = 14;
	localparam int LongConstBits = 30;

	opcodeT op;
	funcT fn;
	lenFieldT lenField;
	logic raZero;
	logic rbZero;
	logic rcZero;
	constT wideConst;

	assign op = opOf(instr_i);
	assign fn = funcOf(instr_i);
	assign lenField = lenOf(instr_i);
	assign raZero = regOf(instr_i, fieldRa) == '0;
	assign rbZero = regOf(instr_i, fieldRb) == '0;
	assign rcZero = regOf(instr_i, fieldRc) == '0;

	// ==============================
	// Source validity
	// ==============================
	// Register 0 reads as zero, so it never waits on a producer
	always_comb
	begin
		case (op)
			opBcc, opBbc, opBeqi, opChk, opR2, opMemNdx, opBitfield, opCsrrw:
				src1Valid_o = raZero;
			opAddi, opSlti, opSltui, opSgti, opSgtui, opAndi, opOri, opXori:
				src1Valid_o = raZero;
			opXnori, opMului, opAmo, opInc, opCas, opJal, opRet:
				src1Valid_o = raZero;
			opLb, opLbu, opLx, opLxu, opLwr, opLv, opSb, opSx, opSwc, opSv:
				src1Valid_o = raZero;
			default:
				src1Valid_o = 1'b1;
		endcase
	end

	always_comb
	begin
		case (op)
			opBcc, opChk, opSb, opSx, opSwc, opCas, opRet:
				src2Valid_o = rbZero;
			opR2:
				case (fn)
					fnR1:
						src2Valid_o = 1'b1;
					// Bit 25 selects the immediate shift amount
					fnShiftR:
						src2Valid_o = instr_i[25] || rbZero;
					default:
						src2Valid_o = rbZero;
				endcase
			opMemNdx:
				src2Valid_o = (fn inside {fnLvx, fnSvx}) ? 1'b0 : rbZero;
			opSv:
				src2Valid_o = 1'b0;
			opAmo:
				src2Valid_o = instr_i[31] || rbZero;
			default:
				src2Valid_o = 1'b1;
		endcase
	end

	always_comb
	begin
		case (op)
			opChk:
				src3Valid_o = rcZero;
			opR2:
				src3Valid_o = (lenField != lenSix && fn == fnMaj) ? rcZero : 1'b1;
			opMemNdx:
				src3Valid_o = (lenField == lenFour && (fn inside {fnSbx, fnScx, fnShx,
					fnSwx, fnSwcx, fnCasx})) ? rcZero : 1'b1;
			default:
				src3Valid_o = 1'b1;
		endcase
	end

	// ==============================
	// Constant and register write
	// ==============================
	assign hasConst_o = op inside {opAddi, opSlti, opSltui, opSgti, opSgtui, opAndi,
		opOri, opXori, opXnori, opMului, opMuli, opDivui, opDivi, opModi, opLb, opLbu,
		opLx, opLwr, opLv, opSb, opSx, opSwc, opSv, opInc, opCas, opJal, opCall, opRet};

	always_comb
	begin
		case (op)
			opR2:
				isRfw_o = lenField == lenFour && (fn inside {fnR1, fnAdd, fnSub, fnSlt,
					fnSltu, fnAnd, fnOr, fnXor, fnMulu, fnMulsu, fnMul, fnDivModu,
					fnDivModsu, fnDivMod, fnMov, fnShiftR, fnMin, fnMax});
			opMemNdx:
				isRfw_o = lenField == lenFour && (fn inside {fnLbx, fnLbux, fnLcx,
					fnLcux, fnLhx, fnLhux, fnLwx, fnLwrx, fnLvx, fnCasx});
			opBitfield, opAddi, opSlti, opSltui, opSgti, opSgtui, opAndi, opOri:
				isRfw_o = 1'b1;
			opXori, opMului, opMuli, opDivui, opDivi, opModi, opCsrrw:
				isRfw_o = 1'b1;
			opJal, opCall, opRet, opLb, opLbu, opLx, opLwr, opLv, opCas, opAmo:
				isRfw_o = 1'b1;
			default:
				isRfw_o = 1'b0;
		endcase
	end

	// 6-byte form carries a 30-bit constant, others 14 bits
	assign wideConst = (lenField == lenSix)
		? {{($bits(constT) - LongConstBits){instr_i[47]}}, instr_i[47:ConstLo]}
		: {{($bits(constT) - ShortConstBits){instr_i[31]}}, instr_i[31:ConstLo]};

	assign const_o = wideConst[ConstWidth-1:0];

	always_comb
	begin
		case (lenField)
			lenFour:
				len_o = 3'd4;
			lenSix:
				len_o = 3'd6;
			default:
				len_o = 3'd2;
		endcase
	end

endmodule

// File: source/unitClassifier.sv
// Execution-unit classifier: unit class and control-flow class of one instruction
`timescale 1ns/1ps

module unitClassifier (
	input  isaPkg::instrT instr_i,
	output logic          isAlu_o,
	output logic          isAlu0_o,
	output logic          isFpu_o,
	output logic          isFlowCtrl_o,
	output logic          isBranch_o,
	output logic          isJump_o,
	output logic          isSync_o
);
	import isaPkg::*;

	opcodeT op;
	funcT fn;
	logic short32;
	logic isRti;
	logic isBrk;
	logic isR1Sync;

	assign op = opOf(instr_i);
	assign fn = funcOf(instr_i);

	// S2 is only a function code in the 4-byte form
	assign short32 = lenOf(instr_i) == lenFour;

	assign isRti = op == opR2 && short32 && fn == fnRti;
	assign isBrk = op == opBrk && short32;
	assign isR1Sync = op == opR2 && short32 && fn == fnR1
		&& regOf(instr_i, fieldR1Func) == fnSync;

	// ==============================
	// Unit selection
	// ==============================
	always_comb
	begin
		case (op)
			opR2:
				isAlu_o = !isRti;
			opBrk, opBcc, opBbc, opBeqi, opChk:
				isAlu_o = 1'b0;
			opJal, opJmp, opCall, opRet:
				isAlu_o = 1'b0;
			opFloat:
				isAlu_o = 1'b0;
			default:
				isAlu_o = 1'b1;
		endcase
	end

	// Long-latency and CSR work only lives on ALU 0
	always_comb
	begin
		case (op)
			opR2:
				if (short32)
				begin
					case (fn)
						fnR1, fnShiftR, fnMin, fnMax:
							isAlu0_o = 1'b1;
						fnMulu, fnMulsu, fnMul:
							isAlu0_o = 1'b1;
						fnDivModu, fnDivModsu, fnDivMod:
							isAlu0_o = 1'b1;
						default:
							isAlu0_o = 1'b0;
					endcase
				end
				else
					isAlu0_o = 1'b0;
			opMemNdx, opBitfield, opCsrrw:
				isAlu0_o = 1'b1;
			opMului, opMuli, opDivui, opDivi, opModi:
				isAlu0_o = 1'b1;
			default:
				isAlu0_o = 1'b0;
		endcase
	end

	assign isFpu_o = op == opFloat;

	// ==============================
	// Control flow
	// ==============================
	// Predictable conditional branches only
	assign isBranch_o = op inside {opBcc, opBbc, opBeqi, opChk};

	assign isFlowCtrl_o = isBranch_o || isRti
		|| (op inside {opBrk, opJal, opJmp, opCall, opRet});

	// Bit 7 set selects the register-indirect form
	assign isJump_o = op == opJmp && !instr_i[7];

	assign isSync_o = isR1Sync || isBrk || isRti;

endmodule

// File: verif/decoderTrace.txt
# name instr(hex) rt(hex) predictTaken flags(hex) const(hex) len(bytes)
# flags bit 18..0: isAlu isAlu0 isFpu isFlowCtrl isBranch branchTaken isJump isSync
# isLoad preload isMem isMemNdx isRmw canExcept src1Valid src2Valid src3Valid hasConst rfw
aluAdd 000010004102 03 0 40025 0000000000000400 4
alu0Mul 000068000002 04 0 6003d 0000000000001a00 4
fpuAdd 000010004110 05 0 1003c 0000000000000400 4
branchTaken 0000fff84128 00 1 0e024 fffffffffffffffe 4
branchNotTaken 0000fff84128 00 0 0c024 fffffffffffffffe 4
jmpDirect 000004000031 00 0 0901c 0000000000000100 4
jmpIndirect 0000040000b1 00 0 0801c 0000000000000100 2
brk 000000000000 00 0 0881c 0000000000000000 4
rti 0000c8000002 00 0 0883c fffffffffffff200 4
sync 000004080002 00 0 6081c 0000000000000102 4
loadDirect 000000400118 06 0 4052f 0000000000000010 4
loadPreload 000000400118 00 0 4072e 0000000000000010 4
loadIndexed 0000180c4116 07 0 605a5 0000000000000603 4
storeIndexed 00004c040016 00 0 601b8 0000000000001301 4
store 000000204121 00 0 40126 0000000000000008 4
cas 00000000411e 08 0 40167 0000000000000000 4
amo 000000004117 09 0 40165 0000000000000000 4
inc 000000040115 00 0 4016e 0000000000000001 4
shiftImm 000042006102 0a 0 6000d 0000000000001080 4
majSrc3 000030100002 0b 0 40018 0000000000000c04 4
chkTaken 00000014012b 00 1 0e028 0000000000000005 4
csrrw 000000000105 10 0 6000d 0000000000000000 4
addiShortNeg 0000800000c4 0c 0 4003f ffffffffffffe000 2
addiFourNeg 0000fffc0204 0f 0 4002f ffffffffffffffff 4
addiLongPos 48d159e00144 0d 0 4002f 0000000012345678 6
addiLongNeg ffffffc00044 0e 0 4003f fffffffffffffff0 6

// File: verif/instrDecoderTb.sv
// Testbench for the instruction pre-decoder that replays a trace and checks every output
`timescale 1ns/1ps

module instrDecoderTb;
	import isaPkg::*;
	import decodePkg::*;

	localparam int IdWidth = DefIdWidth;
	localparam int ConstWidth = DefConstWidth;
	localparam int ResetCycles = 10;
	localparam int FlagBits = 19;

	logic clk;
	logic arstN_i;
	logic idv_i;
	logic [IdWidth-1:0] id_i;
	instrT instr_i;
	regIdxT rt_i;
	logic predictTaken_i;

	logic idv_o;
	logic [IdWidth-1:0] id_o;
	logic [ConstWidth-1:0] const_o;
	lenT len_o;
	logic isAlu_o;
	logic isAlu0_o;
	logic isFpu_o;
	logic isFlowCtrl_o;
	logic isBranch_o;
	logic branchTaken_o;
	logic isJump_o;
	logic isSync_o;
	logic isLoad_o;
	logic preload_o;
	logic isMem_o;
	logic isMemNdx_o;
	logic isRmw_o;
	logic canExcept_o;
	logic src1Valid_o;
	logic src2Valid_o;
	logic src3Valid_o;
	logic hasConst_o;
	logic rfw_o;

	// Trace contents with one entry per instruction
	string names[$];
	instrT instrs[$];
	regIdxT rts[$];
	logic predicts[$];
	logic [FlagBits-1:0] expFlags[$];
	constT expConsts[$];
	lenT expLens[$];

	// Expectation for the instruction driven on the previous falling edge
	logic pendValid;
	int pendIdx;
	logic [IdWidth-1:0] pendId;
	string pendName;

	int cycleCount;
	int cycleLimit;

	instrDecoder #(
		.IdWidth    (IdWidth),
		.ConstWidth (ConstWidth)
	) i_instrDecoder (
		.clk            (clk),
		.arstN_i        (arstN_i),
		.idv_i          (idv_i),
		.id_i           (id_i),
		.instr_i        (instr_i),
		.rt_i           (rt_i),
		.predictTaken_i (predictTaken_i),
		.idv_o          (idv_o),
		.id_o           (id_o),
		.const_o        (const_o),
		.len_o          (len_o),
		.isAlu_o        (isAlu_o),
		.isAlu0_o       (isAlu0_o),
		.isFpu_o        (isFpu_o),
		.isFlowCtrl_o   (isFlowCtrl_o),
		.isBranch_o     (isBranch_o),
		.branchTaken_o  (branchTaken_o),
		.isJump_o       (isJump_o),
		.isSync_o       (isSync_o),
		.isLoad_o       (isLoad_o),
		.preload_o      (preload_o),
		.isMem_o        (isMem_o),
		.isMemNdx_o     (isMemNdx_o),
		.isRmw_o        (isRmw_o),
		.canExcept_o    (canExcept_o),
		.src1Valid_o    (src1Valid_o),
		.src2Valid_o    (src2Valid_o),
		.src3Valid_o    (src3Valid_o),
		.hasConst_o     (hasConst_o),
		.rfw_o          (rfw_o)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// ==============================
	// Helpers
	// ==============================
	task automatic failRun(input string why);
		$display("%s", why);
		$display("Simulation finished: FAIL");
		$fatal(1, "decoder testbench stopped at first error");
	endtask

	// Flag word in trace order with isAlu in bit 18 and rfw in bit 0
	function automatic logic [FlagBits-1:0] packFlags();
		return {isAlu_o, isAlu0_o, isFpu_o, isFlowCtrl_o, isBranch_o, branchTaken_o,
			isJump_o, isSync_o, isLoad_o, preload_o, isMem_o, isMemNdx_o, isRmw_o,
			canExcept_o, src1Valid_o, src2Valid_o, src3Valid_o, hasConst_o, rfw_o};
	endfunction

	task automatic loadTrace();
		int fd;
		int got;
		string word;
		string rest;
		instrT inW;
		regIdxT rtW;
		logic ptW;
		logic [FlagBits-1:0] flagW;
		constT constW;
		int lenW;
		fd = $fopen("verif/decoderTrace.txt", "r");
		if (fd == 0)
			failRun("Could not open the trace file verif/decoderTrace.txt");
		while (!$feof(fd))
		begin
			got = $fscanf(fd, "%s", word);
			if (got != 1)
				break;
			// Comment lines are skipped whole
			if (word.substr(0, 0) == "#")
				got = $fgets(rest, fd);
			else
			begin
				got = $fscanf(fd, "%h %h %h %h %h %d", inW, rtW, ptW, flagW, constW, lenW);
				if (got != 6)
					failRun($sformatf("Trace line for %s has missing or bad fields", word));
				names.push_back(word);
				instrs.push_back(inW);
				rts.push_back(rtW);
				predicts.push_back(ptW);
				expFlags.push_back(flagW);
				expConsts.push_back(constW);
				expLens.push_back(lenT'(lenW));
			end
		end
		$fclose(fd);
		if (names.size() == 0)
			failRun("The trace file holds no instructions");
	endtask

	task automatic checkPending();
		logic [FlagBits-1:0] gotFlags;
		string name;
		if (!pendValid)
		begin
			assert (idv_o === 1'b0)
			else
				failRun($sformatf("ERROR %s: idv_o expected 0 actual %b", pendName, idv_o));
			return;
		end
		name = pendName;
		gotFlags = packFlags();
		assert (idv_o === 1'b1)
		else
			failRun($sformatf("ERROR %s: idv_o expected 1 actual %b", name, idv_o));
		assert (id_o === pendId)
		else
			failRun($sformatf("ERROR %s: id_o expected %h actual %h", name, pendId, id_o));
		assert (gotFlags === expFlags[pendIdx])
		else
			failRun($sformatf("ERROR %s: flags expected %h actual %h", name,
				expFlags[pendIdx], gotFlags));
		assert (const_o === expConsts[pendIdx])
		else
			failRun($sformatf("ERROR %s: const_o expected %h actual %h", name,
				expConsts[pendIdx], const_o));
		assert (len_o === expLens[pendIdx])
		else
			failRun($sformatf("ERROR %s: len_o expected %0d actual %0d", name,
				expLens[pendIdx], len_o));
	endtask

	// Checks the previous cycle and drives the next one on the falling edge
	task automatic driveAndCheck(input logic valid, input int idx);
		logic [IdWidth-1:0] tag;
		@(negedge clk);
		checkPending();
		tag = $urandom_range((1 << IdWidth) - 1, 0);
		idv_i = valid;
		id_i = tag;
		if (valid)
		begin
			instr_i = instrs[idx];
			rt_i = rts[idx];
			predictTaken_i = predicts[idx];
		end
		pendValid = valid;
		pendIdx = idx;
		pendId = tag;
		pendName = valid ? names[idx] : "idle gap";
	endtask

	// ==============================
	// Timeout
	// ==============================
	always @(posedge clk)
	begin
		cycleCount++;
		if (cycleLimit > 0 && cycleCount > cycleLimit)
			failRun($sformatf("Timeout after %0d cycles, the trace did not complete",
				cycleCount));
	end

	// ==============================
	// Main sequence
	// ==============================
	initial
	begin
		void'($urandom(32'hf5746343));
		arstN_i = 1'b0;
		idv_i = 1'b0;
		id_i = '0;
		instr_i = '0;
		rt_i = '0;
		predictTaken_i = 1'b0;
		pendValid = 1'b0;
		pendIdx = 0;
		pendId = '0;
		pendName = "";
		cycleCount = 0;
		cycleLimit = 0;

		loadTrace();
		cycleLimit = (names.size() + 20) * 4;

		repeat (ResetCycles) @(negedge clk);
		arstN_i = 1'b1;

		// First check confirms idv_o stays low out of reset
		pendValid = 1'b0;
		pendName = "after reset";

		for (int i = 0; i < names.size(); i++)
		begin
			// Occasional idle cycle between instructions
			if ($urandom_range(3, 0) == 0)
				driveAndCheck(1'b0, 0);
			driveAndCheck(1'b1, i);
		end
		driveAndCheck(1'b0, 0);
		@(negedge clk);
		checkPending();

		$display("Simulation finished: PASS");
		$finish;
	end

endmodule
